// File: verilog/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// instruction word and address width.
`define INST_W 32

// 32 general registers plus hi and lo.
`define LOG_REG_ADDR_W 6

`define REG_RA 31
`define REG_HI 32
`define REG_LO 33

`define UOP_QUEUE_DEPTH 4

`endif

// File: verilog/decodePkg.sv
`include "decode_defines.svh"

package decodePkg;

    typedef logic [`LOG_REG_ADDR_W-1:0] regAddrT;

    typedef struct packed {
        logic [`INST_W-1:0] pc;
        logic [`INST_W-1:0] instWord;
    } fetchPacketT;

    // each hi kind is directly followed by its lo kind.
    typedef enum logic [6:0] {
        NOP_U,
        ADD_U, ADDU_U, ADDI_U, ADDIU_U, SUB_U, SUBU_U,
        SLT_U, SLTU_U, SLTI_U, SLTIU_U,
        AND_U, ANDI_U, OR_U, ORI_U, XOR_U, XORI_U, NOR_U, LUI_U,
        SLL_U, SLLV_U, SRA_U, SRAV_U, SRL_U, SRLV_U,
        MULTHI_U, MULTLO_U, MULTUHI_U, MULTULO_U,
        DIVHI_U, DIVLO_U, DIVUHI_U, DIVULO_U,
        BEQ_U, BNE_U, BGEZ_U, BGTZ_U, BLEZ_U, BLTZ_U, BGEZAL_U, BLTZAL_U,
        J_U, JAL_U, JR_U, JALR_U,
        MFHI_U, MFLO_U, MTHI_U, MTLO_U,
        LB_U, LBU_U, LH_U, LHU_U, LW_U,
        SB_U, SH_U, SW_U, SWL_U, SWR_U
    } uopKindT;

    typedef enum logic [1:0] {UNIT_ALU, UNIT_MDU, UNIT_LSU} unitT;

    typedef enum logic [2:0] {ALU_ARITH, ALU_LOGIC, ALU_SHIFT, ALU_BRANCH, ALU_MOVE} aluTypeT;

    typedef enum logic [1:0] {typeNormal, typeBR, typeJ, typeJR} branchTypeT;

    typedef struct packed {
        logic [`INST_W-1:0] pc;
        uopKindT            kind;
        unitT               unit;
        aluTypeT            aluType;
        regAddrT            op0Addr;
        regAddrT            op1Addr;
        regAddrT            dstAddr;
        logic               op0Re;
        logic               op1Re;
        logic               dstWe;
        logic [`INST_W-1:0] imm;
        branchTypeT         branchType;
        logic [`INST_W-1:0] branchAddr;
    } uopT;

    typedef struct packed {
        uopT  uop0;
        uopT  uop1;
        logic hasSecond;
    } uopPairT;

endpackage

// File: verilog/instDecoder.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module instDecoder (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instValid,
    input  decodePkg::fetchPacketT inst,
    output logic                 instReady,
    output logic                 pairValid,
    output decodePkg::uopPairT   pair,
    input  logic                 pairReady
);
    import decodePkg::*;

    typedef enum logic [1:0] {SRC_NONE, SRC_RS, SRC_RT, SRC_HILO} srcSelT;
    typedef enum logic [2:0] {DST_NONE, DST_RD, DST_RT, DST_RA, DST_HILO} dstSelT;

    // operand routing shared by a group of instructions.
    typedef struct packed {
        srcSelT     op0;
        srcSelT     op1;
        dstSelT     dst;
        branchTypeT br;
        unitT       unit;
    } fmtT;

    typedef struct packed {
        uopKindT kind;
        aluTypeT aluType;
        fmtT     fmt;
    } decEntryT;

    localparam fmtT FMT_NONE = '{SRC_NONE, SRC_NONE, DST_NONE, typeNormal, UNIT_ALU};
    localparam fmtT FMT_R    = '{SRC_RS, SRC_RT, DST_RD, typeNormal, UNIT_ALU};
    localparam fmtT FMT_I    = '{SRC_RS, SRC_NONE, DST_RT, typeNormal, UNIT_ALU};
    localparam fmtT FMT_SH   = '{SRC_RT, SRC_NONE, DST_RD, typeNormal, UNIT_ALU};
    localparam fmtT FMT_SHV  = '{SRC_RT, SRC_RS, DST_RD, typeNormal, UNIT_ALU};
    localparam fmtT FMT_B2   = '{SRC_RS, SRC_RT, DST_NONE, typeBR, UNIT_ALU};
    localparam fmtT FMT_B1   = '{SRC_RS, SRC_NONE, DST_NONE, typeBR, UNIT_ALU};
    localparam fmtT FMT_BAL  = '{SRC_RS, SRC_NONE, DST_RA, typeBR, UNIT_ALU};
    localparam fmtT FMT_J    = '{SRC_NONE, SRC_NONE, DST_NONE, typeJ, UNIT_ALU};
    localparam fmtT FMT_JAL  = '{SRC_NONE, SRC_NONE, DST_RA, typeJ, UNIT_ALU};
    localparam fmtT FMT_JR   = '{SRC_RS, SRC_NONE, DST_NONE, typeJR, UNIT_ALU};
    localparam fmtT FMT_JALR = '{SRC_RS, SRC_NONE, DST_RD, typeJR, UNIT_ALU};
    localparam fmtT FMT_MD   = '{SRC_RS, SRC_RT, DST_HILO, typeNormal, UNIT_MDU};
    localparam fmtT FMT_MF   = '{SRC_HILO, SRC_NONE, DST_RD, typeNormal, UNIT_ALU};
    localparam fmtT FMT_MT   = '{SRC_RS, SRC_NONE, DST_HILO, typeNormal, UNIT_ALU};
    localparam fmtT FMT_LD   = '{SRC_RS, SRC_NONE, DST_RT, typeNormal, UNIT_LSU};
    localparam fmtT FMT_ST   = '{SRC_RS, SRC_RT, DST_NONE, typeNormal, UNIT_LSU};

    localparam decEntryT NOP_ENTRY = '{NOP_U, ALU_ARITH, FMT_NONE};

    logic [`INST_W-1:0] word;
    logic [5:0]         opcode;
    logic [5:0]         funct;
    regAddrT            rs;
    regAddrT            rt;
    regAddrT            rd;
    regAddrT            hilo;
    logic [`INST_W-1:0] immSext;
    logic [`INST_W-1:0] shamt;
    decEntryT           dec;
    uopT                u;
    uopPairT            pairNext;
    logic               isUop;

    function automatic regAddrT pickSrc(srcSelT sel, regAddrT a, regAddrT b, regAddrT c);
        case (sel)
            SRC_RS:   return a;
            SRC_RT:   return b;
            SRC_HILO: return c;
            default:  return '0;
        endcase
    endfunction

    assign word    = inst.instWord;
    assign opcode  = word[31:26];
    assign funct   = word[5:0];
    assign rs      = {{(`LOG_REG_ADDR_W-5){1'b0}}, word[25:21]};
    assign rt      = {{(`LOG_REG_ADDR_W-5){1'b0}}, word[20:16]};
    assign rd      = {{(`LOG_REG_ADDR_W-5){1'b0}}, word[15:11]};
    assign immSext = {{(`INST_W-16){word[15]}}, word[15:0]};
    assign shamt   = {{(`INST_W-5){1'b0}}, word[10:6]};

    always_comb begin
        dec = NOP_ENTRY;
        if (word != '0) begin       // all-zero word is the nop.
            priority case (opcode)
                6'h00: begin
                    case (funct)
                        6'h00: dec = '{SLL_U, ALU_SHIFT, FMT_SH};
                        6'h02: dec = '{SRL_U, ALU_SHIFT, FMT_SH};
                        6'h03: dec = '{SRA_U, ALU_SHIFT, FMT_SH};
                        6'h04: dec = '{SLLV_U, ALU_SHIFT, FMT_SHV};
                        6'h06: dec = '{SRLV_U, ALU_SHIFT, FMT_SHV};
                        6'h07: dec = '{SRAV_U, ALU_SHIFT, FMT_SHV};
                        6'h08: dec = '{JR_U, ALU_BRANCH, FMT_JR};
                        6'h09: dec = '{JALR_U, ALU_BRANCH, FMT_JALR};
                        6'h10: dec = '{MFHI_U, ALU_MOVE, FMT_MF};
                        6'h11: dec = '{MTHI_U, ALU_MOVE, FMT_MT};
                        6'h12: dec = '{MFLO_U, ALU_MOVE, FMT_MF};
                        6'h13: dec = '{MTLO_U, ALU_MOVE, FMT_MT};
                        6'h18: dec = '{MULTHI_U, ALU_ARITH, FMT_MD};
                        6'h19: dec = '{MULTUHI_U, ALU_ARITH, FMT_MD};
                        6'h1a: dec = '{DIVHI_U, ALU_ARITH, FMT_MD};
                        6'h1b: dec = '{DIVUHI_U, ALU_ARITH, FMT_MD};
                        6'h20: dec = '{ADD_U, ALU_ARITH, FMT_R};
                        6'h21: dec = '{ADDU_U, ALU_ARITH, FMT_R};
                        6'h22: dec = '{SUB_U, ALU_ARITH, FMT_R};
                        6'h23: dec = '{SUBU_U, ALU_ARITH, FMT_R};
                        6'h24: dec = '{AND_U, ALU_LOGIC, FMT_R};
                        6'h25: dec = '{OR_U, ALU_LOGIC, FMT_R};
                        6'h26: dec = '{XOR_U, ALU_LOGIC, FMT_R};
                        6'h27: dec = '{NOR_U, ALU_LOGIC, FMT_R};
                        6'h2a: dec = '{SLT_U, ALU_ARITH, FMT_R};
                        6'h2b: dec = '{SLTU_U, ALU_ARITH, FMT_R};
                        default: dec = NOP_ENTRY;   // syscall, break and the rest.
                    endcase
                end
                6'h01: begin
                    case (word[20:16])
                        5'h00: dec = '{BLTZ_U, ALU_BRANCH, FMT_B1};
                        5'h01: dec = '{BGEZ_U, ALU_BRANCH, FMT_B1};
                        5'h10: dec = '{BLTZAL_U, ALU_BRANCH, FMT_BAL};
                        5'h11: dec = '{BGEZAL_U, ALU_BRANCH, FMT_BAL};
                        default: dec = NOP_ENTRY;
                    endcase
                end
                6'h02: dec = '{J_U, ALU_BRANCH, FMT_J};
                6'h03: dec = '{JAL_U, ALU_BRANCH, FMT_JAL};
                6'h04: dec = '{BEQ_U, ALU_BRANCH, FMT_B2};
                6'h05: dec = '{BNE_U, ALU_BRANCH, FMT_B2};
                6'h06: dec = '{BLEZ_U, ALU_BRANCH, FMT_B1};
                6'h07: dec = '{BGTZ_U, ALU_BRANCH, FMT_B1};
                6'h08: dec = '{ADDI_U, ALU_ARITH, FMT_I};
                6'h09: dec = '{ADDIU_U, ALU_ARITH, FMT_I};
                6'h0a: dec = '{SLTI_U, ALU_ARITH, FMT_I};
                6'h0b: dec = '{SLTIU_U, ALU_ARITH, FMT_I};
                6'h0c: dec = '{ANDI_U, ALU_LOGIC, FMT_I};
                6'h0d: dec = '{ORI_U, ALU_LOGIC, FMT_I};
                6'h0e: dec = '{XORI_U, ALU_LOGIC, FMT_I};
                6'h0f: dec = '{LUI_U, ALU_LOGIC, FMT_I};
                6'h20: dec = '{LB_U, ALU_ARITH, FMT_LD};
                6'h21: dec = '{LH_U, ALU_ARITH, FMT_LD};
                6'h23: dec = '{LW_U, ALU_ARITH, FMT_LD};
                6'h24: dec = '{LBU_U, ALU_ARITH, FMT_LD};
                6'h25: dec = '{LHU_U, ALU_ARITH, FMT_LD};
                6'h28: dec = '{SB_U, ALU_ARITH, FMT_ST};
                6'h29: dec = '{SH_U, ALU_ARITH, FMT_ST};
                6'h2a: dec = '{SWL_U, ALU_ARITH, FMT_ST};
                6'h2b: dec = '{SW_U, ALU_ARITH, FMT_ST};
                6'h2e: dec = '{SWR_U, ALU_ARITH, FMT_ST};
                default: dec = NOP_ENTRY;
            endcase
        end
    end

    always_comb begin
        // md and the hi moves use hi, everything else lo.
        if (dec.fmt.unit == UNIT_MDU || dec.kind inside {MFHI_U, MTHI_U}) begin
            hilo = regAddrT'(`REG_HI);
        end else begin
            hilo = regAddrT'(`REG_LO);
        end
        u            = '0;
        u.pc         = inst.pc;
        u.kind       = dec.kind;
        u.unit       = dec.fmt.unit;
        u.aluType    = dec.aluType;
        u.op0Addr    = pickSrc(dec.fmt.op0, rs, rt, hilo);
        u.op1Addr    = pickSrc(dec.fmt.op1, rs, rt, hilo);
        u.op0Re      = dec.fmt.op0 != SRC_NONE;
        u.op1Re      = dec.fmt.op1 != SRC_NONE;
        u.dstWe      = dec.fmt.dst != DST_NONE;
        u.imm        = (dec.fmt == FMT_SH) ? shamt : immSext;
        u.branchType = dec.fmt.br;
        case (dec.fmt.dst)
            DST_RD:   u.dstAddr = rd;
            DST_RT:   u.dstAddr = rt;
            DST_RA:   u.dstAddr = regAddrT'(`REG_RA);
            DST_HILO: u.dstAddr = hilo;
            default:  u.dstAddr = '0;
        endcase
        case (dec.fmt.br)
            typeBR:  u.branchAddr = {immSext[`INST_W-3:0], 2'b00};
            typeJ:   u.branchAddr = {word[31:28], word[25:0], 2'b00};  // region target.
            default: u.branchAddr = '0;
        endcase

        pairNext           = '0;
        pairNext.uop0      = u;
        pairNext.hasSecond = dec.fmt.unit == UNIT_MDU;
        if (pairNext.hasSecond) begin
            pairNext.uop1         = u;
            pairNext.uop1.kind    = uopKindT'(dec.kind + 1'b1);
            pairNext.uop1.dstAddr = regAddrT'(`REG_LO);
        end
    end

    assign isUop     = dec.kind != NOP_U;
    assign instReady = !pairValid || pairReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pairValid <= 1'b0;
        end else if (instReady) begin
            pairValid <= instValid && isUop;    // nops are taken but not loaded.
        end
    end

    always_ff @(posedge clk) begin
        if (instReady && instValid && isUop) begin
            pair <= pairNext;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        pairValid && !pairReady |=> pairValid && $stable(pair))
        else $error("decoder pair changed under stall");

endmodule

// File: verilog/uopQueue.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module uopQueue (
    input  logic               clk,
    input  logic               rstN,
    input  logic               pairValid,
    input  decodePkg::uopPairT pair,
    output logic               pairReady,
    output logic               headValid,
    output decodePkg::uopPairT head,
    input  logic               headReady
);
    import decodePkg::*;

    localparam int PTR_W = $clog2(`UOP_QUEUE_DEPTH);
    localparam logic [PTR_W:0]   FULL    = (PTR_W+1)'(`UOP_QUEUE_DEPTH);
    localparam logic [PTR_W-1:0] LAST_IX = PTR_W'(`UOP_QUEUE_DEPTH - 1);

    uopPairT          mem [`UOP_QUEUE_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;    // ring entries, head slot excluded.
    logic             push;
    logic             pop;
    logic             load;

    assign pairReady = count != FULL;
    assign push      = pairValid && pairReady;
    assign pop       = headValid && headReady;
    assign load      = (count != '0) && (!headValid || pop);  // refill the head slot.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            headValid <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LAST_IX) ? '0 : wrPtr + 1'b1;
            end
            if (load) begin
                rdPtr <= (rdPtr == LAST_IX) ? '0 : rdPtr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, load};
            if (load) begin
                headValid <= 1'b1;
            end else if (pop) begin
                headValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pair;
        end
        if (load) begin
            head <= mem[rdPtr];
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) count <= FULL)
        else $error("uop queue overflow");

endmodule

// File: verilog/uopSerializer.sv
`timescale 1ns/1ps

module uopSerializer (
    input  logic               clk,
    input  logic               rstN,
    input  logic               headValid,
    input  decodePkg::uopPairT head,
    output logic               headReady,
    output logic               uopValid,
    output decodePkg::uopT     uop,
    input  logic               uopReady
);
    import decodePkg::*;

    logic phase;        // high while uop1 is on the output.
    logic lastUop;
    logic fire;

    assign uopValid  = headValid;
    assign uop       = phase ? head.uop1 : head.uop0;
    assign lastUop   = phase || !head.hasSecond;
    assign fire      = uopValid && uopReady;
    assign headReady = fire && lastUop;     // pop only on the final uop.

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= 1'b0;
        end else if (fire) begin
            phase <= !lastUop;
        end
    end

    // the queue must hold its head while the output stalls.
    assert property (@(posedge clk) disable iff (!rstN)
        uopValid && !uopReady |=> uopValid && $stable(uop))
        else $error("uop changed under stall");

endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instValid,
    input  decodePkg::fetchPacketT inst,
    output logic                   instReady,
    output logic                   uopValid,
    output decodePkg::uopT         uop,
    input  logic                   uopReady
);
    import decodePkg::*;

    logic    pairValid;
    logic    pairReady;
    uopPairT pair;
    logic    headValid;
    logic    headReady;
    uopPairT head;

    instDecoder i_decoder (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .inst      (inst),
        .instReady (instReady),
        .pairValid (pairValid),
        .pair      (pair),
        .pairReady (pairReady)
    );

    uopQueue i_queue (
        .clk       (clk),
        .rstN      (rstN),
        .pairValid (pairValid),
        .pair      (pair),
        .pairReady (pairReady),
        .headValid (headValid),
        .head      (head),
        .headReady (headReady)
    );

    uopSerializer i_serializer (
        .clk       (clk),
        .rstN      (rstN),
        .headValid (headValid),
        .head      (head),
        .headReady (headReady),
        .uopValid  (uopValid),
        .uop       (uop),
        .uopReady  (uopReady)
    );

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int HALF_PERIOD = 10  // 20 ns period.
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = !clk;
    end

endmodule

// File: tests/decodeStageTb.sv
`timescale 1ns/1ps
`include "decode_defines.svh"

module decodeStageTb;
    import decodePkg::*;

    typedef struct packed {
        uopKindT            kind;
        regAddrT            op0;
        regAddrT            op1;
        regAddrT            dst;
        logic [`INST_W-1:0] imm;
        logic [`INST_W-1:0] br;
    } expUopT;

    typedef struct packed {
        logic [`INST_W-1:0] pc;
        logic [`INST_W-1:0] word;
        logic [1:0]         count;
        expUopT             e0;
        expUopT             e1;
    } testEntryT;

    typedef struct packed {
        logic [7:0]         run;
        logic [`INST_W-1:0] pc;
        expUopT             e;
    } sbItemT;

    localparam regAddrT DC     = '1;    // operand not checked.
    localparam expUopT  NO_UOP = '0;
    localparam int      MAX_RUNS = 64;

    logic        clk;
    logic        rstN;
    logic        instValid;
    fetchPacketT inst;
    logic        instReady;
    logic        uopValid;
    uopT         uop;
    logic        uopReady = 1'b0;

    testEntryT tests[$];
    string     names[$];
    sbItemT    expQ[$];
    string     runNames [MAX_RUNS];
    int        remaining [MAX_RUNS];
    int        runErrs [MAX_RUNS];
    int        passCount = 0;
    int        failCount = 0;
    int        otherErrs = 0;
    int        cycles = 0;
    int        cycleLimit = 0;
    integer    seed = 32'hbdd9;
    logic      stallMode = 1'b0;

    clockGen i_clkGen (.clk(clk));

    decodeStage i_dut (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .inst      (inst),
        .instReady (instReady),
        .uopValid  (uopValid),
        .uop       (uop),
        .uopReady  (uopReady)
    );

    function automatic expUopT mk(uopKindT kind, regAddrT op0, regAddrT op1, regAddrT dst,
                                  logic [`INST_W-1:0] imm, logic [`INST_W-1:0] br);
        return expUopT'{kind, op0, op1, dst, imm, br};
    endfunction

    function automatic int pendingUops();
        int n;
        n = 0;
        foreach (expQ[k]) begin
            if (expQ[k].e.kind != NOP_U) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic addTest(string name, logic [`INST_W-1:0] pc, logic [`INST_W-1:0] word,
                           logic [1:0] count, expUopT e0, expUopT e1);
        tests.push_back(testEntryT'{pc, word, count, e0, e1});
        names.push_back(name);
    endtask

    task automatic buildTable();
        addTest("add", 32'h400000, 32'h00221820, 1, mk(ADD_U, DC, DC, 3, 32'h1820, 0), NO_UOP);
        addTest("and", 32'h400004, 32'h00c72824, 1, mk(AND_U, DC, DC, 5, 32'h2824, 0), NO_UOP);
        addTest("sllv", 32'h400008, 32'h01494004, 1, mk(SLLV_U, DC, DC, 8, 32'h4004, 0), NO_UOP);
        addTest("sll", 32'h40000c, 32'h000521c0, 1, mk(SLL_U, DC, DC, 4, 32'h7, 0), NO_UOP);
        addTest("addi", 32'h400010, 32'h2022fffc, 1,
                mk(ADDI_U, DC, DC, 2, 32'hfffffffc, 0), NO_UOP);
        addTest("ori", 32'h400014, 32'h358b8001, 1,
                mk(ORI_U, DC, DC, 11, 32'hffff8001, 0), NO_UOP);
        addTest("lui", 32'h400018, 32'h3c0d1234, 1, mk(LUI_U, DC, DC, 13, 32'h1234, 0), NO_UOP);
        addTest("lw", 32'h40001c, 32'h8deefff8, 1,
                mk(LW_U, DC, DC, 14, 32'hfffffff8, 0), NO_UOP);
        addTest("sw", 32'h400020, 32'hae30000c, 1, mk(SW_U, DC, 16, 0, 32'hc, 0), NO_UOP);
        addTest("mult", 32'h400024, 32'h02530018, 2, mk(MULTHI_U, 18, 19, 32, 32'h18, 0),
                mk(MULTLO_U, 18, 19, 33, 32'h18, 0));
        addTest("multu", 32'h400028, 32'h00220019, 2, mk(MULTUHI_U, 1, 2, 32, 32'h19, 0),
                mk(MULTULO_U, 1, 2, 33, 32'h19, 0));
        addTest("div", 32'h40002c, 32'h0064001a, 2, mk(DIVHI_U, 3, 4, 32, 32'h1a, 0),
                mk(DIVLO_U, 3, 4, 33, 32'h1a, 0));
        addTest("divu", 32'h400030, 32'h00a6001b, 2, mk(DIVUHI_U, 5, 6, 32, 32'h1b, 0),
                mk(DIVULO_U, 5, 6, 33, 32'h1b, 0));
        addTest("mfhi", 32'h400034, 32'h0000a010, 1,
                mk(MFHI_U, 32, DC, 20, 32'hffffa010, 0), NO_UOP);
        addTest("mtlo", 32'h400038, 32'h02a00013, 1, mk(MTLO_U, 21, DC, 33, 32'h13, 0), NO_UOP);
        addTest("beq", 32'h40003c, 32'h1022fffd, 1,
                mk(BEQ_U, DC, DC, 0, 32'hfffffffd, 32'hfffffff4), NO_UOP);
        addTest("bgezal", 32'h400040, 32'h04f10010, 1,
                mk(BGEZAL_U, DC, DC, 31, 32'h10, 32'h40), NO_UOP);
        addTest("j", 32'h400044, 32'h08123456, 1,
                mk(J_U, DC, DC, 0, 32'h3456, 32'h0048d158), NO_UOP);
        addTest("jal", 32'h400048, 32'h0eabcdef, 1,
                mk(JAL_U, DC, DC, 31, 32'hffffcdef, 32'h0aaf37bc), NO_UOP);
        addTest("nop", 32'h40004c, 32'h00000000, 0, NO_UOP, NO_UOP);
        addTest("syscall", 32'h400050, 32'h0000000c, 0, NO_UOP, NO_UOP);
        addTest("unknown", 32'h400054, 32'hfc000000, 0, NO_UOP, NO_UOP);
        addTest("addu", 32'h400058, 32'h02f8b021, 1,
                mk(ADDU_U, DC, DC, 22, 32'hffffb021, 0), NO_UOP);
    endtask

    task automatic checkField(int run, string field, logic [31:0] expV, logic [31:0] actV);
        if (expV != actV) begin
            $display("error %s %s: expected %h, actual %h", runNames[run], field, expV, actV);
            runErrs[run]++;
        end
    endtask

    task automatic finishRun(int run);
        if (runErrs[run] == 0) begin
            $display("pass %s", runNames[run]);
            passCount++;
        end else begin
            failCount++;
        end
    endtask

    // in the stall pass the sink takes about one uop in four.
    always @(posedge clk) begin
        if (!rstN) begin
            uopReady <= 1'b0;
        end else if (stallMode) begin
            uopReady <= ($random(seed) & 3) == 0;
        end else begin
            uopReady <= 1'b1;
        end
    end

    always @(posedge clk) begin : collectUops
        sbItemT it;
        if (rstN && uopValid && uopReady) begin
            // an entry without a uop ends once a later uop shows up.
            while (expQ.size() != 0 && expQ[0].e.kind == NOP_U && expQ[0].pc != uop.pc) begin
                it = expQ.pop_front();
                finishRun(it.run);
            end
            if (expQ.size() == 0) begin
                $display("a micro-op at pc %h arrived when none was expected", uop.pc);
                otherErrs++;
            end else begin
                it = expQ.pop_front();
                if (it.e.kind == NOP_U) begin
                    checkField(it.run, "micro-op count", 32'd0, 32'd1);
                    finishRun(it.run);
                end else begin
                    checkField(it.run, "pc", it.pc, uop.pc);
                    checkField(it.run, "kind", 32'(it.e.kind), 32'(uop.kind));
                    if (it.e.op0 != DC) begin
                        checkField(it.run, "op0Addr", 32'(it.e.op0), 32'(uop.op0Addr));
                    end
                    if (it.e.op1 != DC) begin
                        checkField(it.run, "op1Addr", 32'(it.e.op1), 32'(uop.op1Addr));
                    end
                    checkField(it.run, "dstAddr", 32'(it.e.dst), 32'(uop.dstAddr));
                    checkField(it.run, "dstWe", 32'(it.e.dst != 0), 32'(uop.dstWe));
                    checkField(it.run, "imm", it.e.imm, uop.imm);
                    checkField(it.run, "branchAddr", it.e.br, uop.branchAddr);
                    remaining[it.run]--;
                    if (remaining[it.run] == 0) begin
                        finishRun(it.run);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int run;
        testEntryT t;
        sbItemT left;
        instValid = 1'b0;
        inst      = '0;
        rstN      = 1'b0;
        buildTable();
        cycleLimit = 40 * 2 * tests.size() + 50;   // two passes over the table.
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        if (!instReady || uopValid) begin
            $display("after reset instReady was not high or uopValid was not low");
            otherErrs++;
        end
        run = 0;
        for (int p = 0; p < 2; p++) begin
            stallMode <= (p == 1);
            for (int i = 0; i < tests.size(); i++) begin
                t = tests[i];
                runNames[run]  = (p == 0) ? names[i] : {names[i], " under stall"};
                remaining[run] = t.count;
                runErrs[run]   = 0;
                if (t.count == 0) begin
                    expQ.push_back(sbItemT'{8'(run), t.pc, NO_UOP});  // no uop may follow.
                end
                if (t.count > 0) begin
                    expQ.push_back(sbItemT'{8'(run), t.pc, t.e0});
                end
                if (t.count > 1) begin
                    expQ.push_back(sbItemT'{8'(run), t.pc, t.e1});
                end
                instValid <= 1'b1;
                inst      <= fetchPacketT'{t.pc, t.word};
                @(posedge clk);
                while (!instReady) begin
                    @(posedge clk);
                end
                run++;
            end
        end
        instValid <= 1'b0;
        while (pendingUops() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);     // stray micro-ops would show up here.
        while (expQ.size() != 0) begin
            left = expQ.pop_front();
            finishRun(left.run);
        end
        $display("tests passed: %0d, failed: %0d, other errors: %0d",
                 passCount, failCount, otherErrs);
        if (failCount == 0 && otherErrs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verilog
verilog/decodePkg.sv
verilog/instDecoder.sv
verilog/uopQueue.sv
verilog/uopSerializer.sv
verilog/decodeStage.sv
tests/clockGen.sv
tests/decodeStageTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module decodeStageTb
out=$(./obj_dir/VdecodeStageTb)
echo "$out"
if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
